// ==== rtl/bus_pkg.sv ====
package bus_pkg;

    // word addressed bus, one full word per access.
    typedef logic [7:0]  adr_t;
    typedef logic [31:0] data_t;

    // request driven by a master.
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        adr_t  adr;
        data_t dat;
    } wb_req_t;

    // response returned to a master.
    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } wb_rsp_t;

    // address map.
    localparam adr_t RAM_BASE  = 8'h00;
    localparam int   RAM_WORDS = 64;
    localparam int   RAM_AW    = $clog2(RAM_WORDS); // ram word index width.
    localparam adr_t CNT_BASE  = 8'h80;             // one counter per master from here.

    localparam wb_req_t IDLE_REQ = '0;

endpackage

// ==== rtl/arb_pkg.sv ====
package arb_pkg;

    localparam int N_MASTERS = 3;

    // one bit per master, index 0 has the highest priority.
    typedef logic [N_MASTERS-1:0] arb_vector_t;

    typedef logic [1:0] master_id_t;

    localparam arb_vector_t NO_GRANT = '0;

    typedef enum logic {
        READY,
        BUSY
    } arb_state_t;

endpackage

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  arb_pkg::arb_vector_t req,
    input  logic                 bus_term,
    output arb_pkg::arb_vector_t grant
);
    import arb_pkg::*;

    arb_state_t  state;
    arb_vector_t prio_grant;

    // lowest set index wins, scanned downward so it is written last.
    always_comb begin
        prio_grant = NO_GRANT;
        for (int i = N_MASTERS - 1; i >= 0; i--) begin
            if (req[i]) begin
                prio_grant    = NO_GRANT;
                prio_grant[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= READY;
            grant <= NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    if (req != NO_GRANT) begin
                        grant <= prio_grant;
                        state <= BUSY;
                    end
                end

                // hold the owner until its cycle ends, then drop to idle.
                BUSY: begin
                    if (bus_term) begin
                        grant <= NO_GRANT;
                        state <= READY;
                    end
                end

                default: begin
                    grant <= NO_GRANT;
                    state <= READY;
                end
            endcase
        end
    end

endmodule

// ==== rtl/master_mux.sv ====
`timescale 1ns/1ps

module master_mux (
    input  bus_pkg::wb_req_t     m_req [arb_pkg::N_MASTERS],
    output bus_pkg::wb_rsp_t     m_rsp [arb_pkg::N_MASTERS],
    input  arb_pkg::arb_vector_t grant,
    output arb_pkg::arb_vector_t req,
    output bus_pkg::wb_req_t     bus_req,
    input  bus_pkg::wb_rsp_t     bus_rsp,
    output arb_pkg::master_id_t  owner
);
    import bus_pkg::*;
    import arb_pkg::*;

    // a master requests the bus by raising cyc.
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            req[i] = m_req[i].cyc;
        end
    end

    // one-hot to index.
    always_comb begin
        owner = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) begin
                owner = master_id_t'(i);
            end
        end
    end

    always_comb begin
        if (grant == NO_GRANT) begin
            bus_req = IDLE_REQ; // idle between cycles.
        end else begin
            bus_req = m_req[owner];
        end
    end

    // only the owner sees the response.
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) begin
                m_rsp[i] = bus_rsp;
            end else begin
                m_rsp[i] = '0;
            end
        end
    end

endmodule

// ==== rtl/slave_decoder.sv ====
`timescale 1ns/1ps

module slave_decoder (
    input  logic             clk,
    input  logic             reset,
    input  bus_pkg::wb_req_t bus_req,
    output bus_pkg::wb_rsp_t bus_rsp,
    output logic             sel_ram,
    output logic             sel_cnt,
    input  bus_pkg::wb_rsp_t ram_rsp,
    input  bus_pkg::wb_rsp_t cnt_rsp
);
    import bus_pkg::*;
    import arb_pkg::*;

    adr_t ram_off;
    adr_t cnt_off;
    logic strobe;
    logic in_ram;
    logic in_cnt;
    logic err_q;

    assign strobe  = bus_req.cyc && bus_req.stb;
    assign ram_off = bus_req.adr - RAM_BASE;
    assign cnt_off = bus_req.adr - CNT_BASE;
    assign in_ram  = ram_off < adr_t'(RAM_WORDS);
    assign in_cnt  = cnt_off < adr_t'(N_MASTERS);

    assign sel_ram = strobe && in_ram;
    assign sel_cnt = strobe && in_cnt;

    // unmapped strobe gets a single err pulse, same timing as a slave ack.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= strobe && !in_ram && !in_cnt && !err_q;
        end
    end

    assign bus_rsp.ack = ram_rsp.ack | cnt_rsp.ack;
    assign bus_rsp.err = err_q | ram_rsp.err | cnt_rsp.err;

    always_comb begin
        if (sel_ram) begin
            bus_rsp.dat = ram_rsp.dat;
        end else if (sel_cnt) begin
            bus_rsp.dat = cnt_rsp.dat;
        end else begin
            bus_rsp.dat = '0; // nothing mapped here.
        end
    end

endmodule

// ==== rtl/shared_ram.sv ====
`timescale 1ns/1ps

module shared_ram (
    input  logic             clk,
    input  logic             reset,
    input  logic             sel,
    input  bus_pkg::wb_req_t bus_req,
    output bus_pkg::wb_rsp_t rsp
);
    import bus_pkg::*;

    data_t             mem [RAM_WORDS];
    data_t             rd_dat;
    logic              ack_q;
    logic [RAM_AW-1:0] idx;
    logic              access;

    assign idx    = bus_req.adr[RAM_AW-1:0];
    assign access = sel && !ack_q; // first cycle of the strobe.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && bus_req.we) begin
            mem[idx] <= bus_req.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= mem[idx];
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.err = 1'b0;
    assign rsp.dat = rd_dat;

endmodule

// ==== rtl/cycle_counters.sv ====
`timescale 1ns/1ps

module cycle_counters (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  bus_pkg::wb_req_t    bus_req,
    input  bus_pkg::wb_rsp_t    bus_rsp,
    input  arb_pkg::master_id_t owner,
    output bus_pkg::wb_rsp_t    rsp
);
    import bus_pkg::*;
    import arb_pkg::*;

    data_t      count [N_MASTERS];
    data_t      rd_dat;
    logic       ack_q;
    adr_t       cnt_off;
    master_id_t idx;
    logic       clr;

    assign cnt_off = bus_req.adr - CNT_BASE;
    assign idx     = master_id_t'(cnt_off);
    assign clr     = sel && bus_req.we && ack_q; // lands on the same edge as the ack count.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel && !ack_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < N_MASTERS; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_MASTERS; i++) begin
                if (clr && idx == master_id_t'(i)) begin
                    count[i] <= '0;
                end else if (bus_rsp.ack && owner == master_id_t'(i)) begin
                    count[i] <= count[i] + data_t'(1);
                end
            end
        end
    end

    // sampled before this cycle's own ack is counted.
    always_ff @(posedge clk) begin
        if (sel && !ack_q) begin
            rd_dat <= count[idx];
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.err = 1'b0;
    assign rsp.dat = rd_dat;

endmodule

// ==== rtl/shared_bus_top.sv ====
`timescale 1ns/1ps

module shared_bus_top (
    input  logic             clk,
    input  logic             reset,
    input  bus_pkg::wb_req_t m_req [arb_pkg::N_MASTERS],
    output bus_pkg::wb_rsp_t m_rsp [arb_pkg::N_MASTERS]
);
    import bus_pkg::*;
    import arb_pkg::*;

    arb_vector_t req;
    arb_vector_t grant;
    master_id_t  owner;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    wb_rsp_t     ram_rsp;
    wb_rsp_t     cnt_rsp;
    logic        sel_ram;
    logic        sel_cnt;
    logic        bus_term;

    assign bus_term = bus_rsp.ack | bus_rsp.err; // end of the granted cycle.

    bus_arbiter arb0 (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .bus_term (bus_term),
        .grant    (grant)
    );

    master_mux mux0 (
        .m_req   (m_req),
        .m_rsp   (m_rsp),
        .grant   (grant),
        .req     (req),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .owner   (owner)
    );

    slave_decoder dec0 (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .sel_ram (sel_ram),
        .sel_cnt (sel_cnt),
        .ram_rsp (ram_rsp),
        .cnt_rsp (cnt_rsp)
    );

    shared_ram ram0 (
        .clk     (clk),
        .reset   (reset),
        .sel     (sel_ram),
        .bus_req (bus_req),
        .rsp     (ram_rsp)
    );

    cycle_counters cnt0 (
        .clk     (clk),
        .reset   (reset),
        .sel     (sel_cnt),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .owner   (owner),
        .rsp     (cnt_rsp)
    );

endmodule

// ==== verification/shared_bus_tb.sv ====
`timescale 1ns/1ps

module shared_bus_tb;
    import bus_pkg::*;
    import arb_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    logic    clk;
    logic    reset;
    wb_req_t m_req [N_MASTERS];
    wb_rsp_t m_rsp [N_MASTERS];

    // reference model of the ram and the per-master counts.
    data_t       ref_mem    [RAM_WORDS];
    logic        ref_valid  [RAM_WORDS];
    int unsigned shadow_cnt [N_MASTERS];

    data_t      rsp_dat [N_MASTERS];
    logic       rsp_ack [N_MASTERS];
    logic       rsp_err [N_MASTERS];
    logic       op_we   [N_MASTERS];
    adr_t       op_adr  [N_MASTERS];
    data_t      op_dat  [N_MASTERS];
    data_t      op_exp  [N_MASTERS];
    master_id_t term_order [$]; // masters in the order their cycles ended.

    logic [31:0] rng;
    string       test_name;
    int          fail_count;
    int          check_count;
    int          test_count;
    int          fails_at_start;

    shared_bus_top dut0 (
        .clk   (clk),
        .reset (reset),
        .m_req (m_req),
        .m_rsp (m_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        check_count++;
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_owner_order(input string name, input master_id_t exp,
                                     input master_id_t act);
        check_count++;
        if (exp !== act) begin
            $display("[FAIL] %s: expected master %0d, actual master %0d", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            fail_count++;
        end
    endtask

    // one classic wishbone cycle from master m held until ack or err.
    task automatic bus_access(input master_id_t m, input logic we, input adr_t adr,
                              input data_t wdat);
        wb_req_t req;
        int      cycles;
        logic    done;
        req     = IDLE_REQ;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        cycles  = 0;
        done    = 1'b0;
        @(posedge clk);
        #2;
        m_req[m] = req;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            done = m_rsp[m].ack || m_rsp[m].err;
            cycles++;
        end
        if (!done) begin
            $display("timeout in test %s: master %0d saw no ack or err at address %h",
                     test_name, m, adr);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            rsp_ack[m] = m_rsp[m].ack;
            rsp_err[m] = m_rsp[m].err;
            rsp_dat[m] = m_rsp[m].dat;
            term_order.push_back(m);
            if (m_rsp[m].ack) begin
                shadow_cnt[m]++; // every acked cycle counts for its owner.
            end
            @(posedge clk);
            #2;
            m_req[m] = IDLE_REQ;
        end
    endtask

    // the counter value read back is the one from before this cycle.
    task automatic counter_read(input master_id_t m, input int k);
        data_t exp;
        exp = data_t'(shadow_cnt[k]);
        bus_access(m, 1'b0, CNT_BASE + adr_t'(k), '0);
        check_err(test_name, 1'b0, rsp_err[m]);
        check_data(test_name, exp, rsp_dat[m]);
    endtask

    task automatic ram_write(input master_id_t m, input adr_t adr, input data_t dat);
        bus_access(m, 1'b1, adr, dat);
        check_err(test_name, 1'b0, rsp_err[m]);
        ref_mem[adr[RAM_AW-1:0]]   = dat;
        ref_valid[adr[RAM_AW-1:0]] = 1'b1;
    endtask

    task automatic ram_read(input master_id_t m, input adr_t adr);
        bus_access(m, 1'b0, adr, '0);
        check_err(test_name, 1'b0, rsp_err[m]);
        check_data(test_name, ref_mem[adr[RAM_AW-1:0]], rsp_dat[m]);
    endtask

    // masters in mask start in the same cycle.
    task automatic run_round(input arb_vector_t mask);
        fork
            if (mask[0]) bus_access(2'd0, op_we[0], op_adr[0], op_dat[0]);
            if (mask[1]) bus_access(2'd1, op_we[1], op_adr[1], op_dat[1]);
            if (mask[2]) bus_access(2'd2, op_we[2], op_adr[2], op_dat[2]);
        join
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = fail_count;
    endtask

    task automatic end_test();
        test_count++;
        if (fail_count == fails_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, fail_count - fails_at_start);
        end
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        for (int i = 0; i < N_MASTERS; i++) begin
            check_err(test_name, 1'b0, m_rsp[i].ack);
            check_err(test_name, 1'b0, m_rsp[i].err);
        end
        counter_read(2'd1, 1); // own count first while it is still zero.
        counter_read(2'd1, 0);
        counter_read(2'd1, 2);
        end_test();
    endtask

    task automatic test_ram_readback();
        begin_test("ram_readback");
        for (int m = 0; m < N_MASTERS; m++) begin
            ram_write(master_id_t'(m), adr_t'(5 + 7 * m), next_random());
            ram_read(master_id_t'(m), adr_t'(5 + 7 * m));
        end
        end_test();
    endtask

    task automatic test_contention();
        begin_test("contention");
        for (int j = 0; j < N_MASTERS; j++) begin
            op_we[j]  = 1'b1;
            op_adr[j] = adr_t'(16 + j);
            op_dat[j] = next_random();
        end
        term_order.delete();
        run_round(3'b111);
        for (int j = 0; j < N_MASTERS; j++) begin
            check_owner_order(test_name, master_id_t'(j), term_order[j]);
        end
        for (int j = 0; j < N_MASTERS; j++) begin
            check_err(test_name, 1'b0, rsp_err[j]);
            ref_mem[op_adr[j][RAM_AW-1:0]]   = op_dat[j];
            ref_valid[op_adr[j][RAM_AW-1:0]] = 1'b1;
        end
        end_test();
    endtask

    task automatic test_unmapped();
        begin_test("unmapped");
        bus_access(2'd2, 1'b0, 8'h40, '0);
        check_err(test_name, 1'b1, rsp_err[2]);
        check_err(test_name, 1'b0, rsp_ack[2]);
        check_data(test_name, data_t'(0), rsp_dat[2]); // unmapped reads return zero.
        bus_access(2'd0, 1'b1, 8'h90, 32'hdead_beef);
        check_err(test_name, 1'b1, rsp_err[0]);
        check_err(test_name, 1'b0, rsp_ack[0]);
        counter_read(2'd1, 2); // errs leave the counts alone.
        counter_read(2'd1, 0);
        end_test();
    endtask

    task automatic test_random_traffic();
        int          ops;
        int          a;
        logic [31:0] r;
        logic [31:0] r2;
        arb_vector_t mask;
        begin_test("random_traffic");
        ops = 0;
        while (ops < 40) begin
            r    = next_random();
            mask = arb_vector_t'(r[2:0]);
            if (mask == NO_GRANT) begin
                mask = 3'b010;
            end
            for (int j = 0; j < N_MASTERS; j++) begin
                if (mask[j] && ops >= 40) begin
                    mask[j] = 1'b0;
                end else if (mask[j]) begin
                    ops++;
                    a         = (int'(r[13:8]) + 21 * j) % RAM_WORDS; // distinct per round.
                    r2        = next_random();
                    op_adr[j] = adr_t'(a);
                    op_we[j]  = r2[0] || !ref_valid[a];
                    op_dat[j] = r2;
                    op_exp[j] = ref_mem[a];
                end
            end
            run_round(mask);
            for (int j = 0; j < N_MASTERS; j++) begin
                if (mask[j]) begin
                    check_err(test_name, 1'b0, rsp_err[j]);
                    if (op_we[j]) begin
                        ref_mem[op_adr[j][RAM_AW-1:0]]   = op_dat[j];
                        ref_valid[op_adr[j][RAM_AW-1:0]] = 1'b1;
                    end else begin
                        check_data(test_name, op_exp[j], rsp_dat[j]);
                    end
                end
            end
        end
        end_test();
    endtask

    task automatic test_counters();
        begin_test("counters");
        for (int k = 0; k < N_MASTERS; k++) begin
            counter_read(2'd0, k);
        end
        bus_access(2'd1, 1'b1, CNT_BASE + 8'd1, '0);
        check_err(test_name, 1'b0, rsp_err[1]);
        shadow_cnt[1] = 0; // the clear beats this cycle's own ack.
        bus_access(2'd1, 1'b0, CNT_BASE + 8'd1, '0);
        check_data(test_name, data_t'(0), rsp_dat[1]);
        counter_read(2'd0, 1);
        end_test();
    endtask

    // bus rules checked on every cycle.
    always @(negedge clk) begin
        int          n;
        arb_vector_t want;
        if (!reset) begin
            n = 0;
            for (int i = 0; i < N_MASTERS; i++) begin
                if (m_rsp[i].ack) begin
                    n++;
                    want    = NO_GRANT;
                    want[i] = 1'b1;
                    if (dut0.grant !== want) begin
                        $display("master %0d saw an ack while grant was %b", i, dut0.grant);
                        fail_count++;
                    end
                end
            end
            if (n > 1) begin
                $display("%0d masters saw an ack in the same cycle", n);
                fail_count++;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        rng         = 32'h43f9_47d0;
        fail_count  = 0;
        check_count = 0;
        test_count  = 0;
        for (int i = 0; i < N_MASTERS; i++) begin
            m_req[i]      = IDLE_REQ;
            shadow_cnt[i] = 0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_ram_readback();
        test_contention();
        test_unmapped();
        test_random_traffic();
        test_counters();

        $display("tests %0d, checks %0d, failures %0d", test_count, check_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/bus_pkg.sv
rtl/arb_pkg.sv
rtl/bus_arbiter.sv
rtl/master_mux.sv
rtl/slave_decoder.sv
rtl/shared_ram.sv
rtl/cycle_counters.sv
rtl/shared_bus_top.sv
verification/shared_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the shared Wishbone bus testbench.

VERILATOR ?= verilator
TOP       ?= shared_bus_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
